//--- bench/axi_mem_model.sv
`timescale 1ns/1ps

/*
 * axi_mem_model
 * word memory that answers AXI read and write bursts, with ready and
 * valid stalls taken from a mask that the testbench drives
 */
module axi_mem_model #(
    parameter int MEM_WORDS = 1024
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [5:0]       mask_i,
    input  axi_pkg::axi_ar_t ar_i,
    output logic             ar_ready_o,
    output axi_pkg::axi_r_t  r_o,
    input  logic             r_ready_i,
    input  axi_pkg::axi_aw_t aw_i,
    output logic             aw_ready_o,
    input  axi_pkg::axi_w_t  w_i,
    output logic             w_ready_o,
    output axi_pkg::axi_b_t  b_o,
    input  logic             b_ready_i
);
    import axi_pkg::*;

    axi_data_t mem [MEM_WORDS];

    // per-ID read state, only IDs 0 and 1 are used
    int     rd_addr [2];
    int     rd_left [2];
    int     wr_addr;
    logic   wr_active;
    logic   b_pend;
    logic   r_fire;
    logic   sel_id;

    // next port values, worked out on the rising edge
    logic    nxt_ar_ready = 1'b0;
    logic    nxt_aw_ready = 1'b0;
    logic    nxt_w_ready  = 1'b0;
    axi_r_t  nxt_r        = '0;
    axi_b_t  nxt_b        = '0;
    logic    ar_ready_q   = 1'b0;
    logic    aw_ready_q   = 1'b0;
    logic    w_ready_q    = 1'b0;
    axi_r_t  r_q          = '0;
    axi_b_t  b_q          = '0;

    assign ar_ready_o = ar_ready_q;
    assign aw_ready_o = aw_ready_q;
    assign w_ready_o  = w_ready_q;
    assign r_o        = r_q;
    assign b_o        = b_q;

    always @(posedge clk) begin
        if (!rst_n) begin
            rd_left[0] = 0;
            rd_left[1] = 0;
            wr_active  = 1'b0;
            b_pend     = 1'b0;
            nxt_ar_ready = 1'b0;
            nxt_aw_ready = 1'b0;
            nxt_w_ready  = 1'b0;
            nxt_r        = '0;
            nxt_b        = '0;
        end else begin
            // transfers of this edge
            if (ar_i.arvalid && ar_ready_o) begin
                rd_addr[ar_i.arid[0]] = int'(ar_i.araddr >> 2) % MEM_WORDS;
                rd_left[ar_i.arid[0]] = int'(ar_i.arlen) + 1;
            end
            r_fire = r_o.rvalid && r_ready_i;
            if (r_fire) begin
                rd_addr[r_o.rid[0]] = (rd_addr[r_o.rid[0]] + 1) % MEM_WORDS;
                rd_left[r_o.rid[0]] = rd_left[r_o.rid[0]] - 1;
            end
            if (aw_i.awvalid && aw_ready_o) begin
                wr_addr   = int'(aw_i.awaddr >> 2) % MEM_WORDS;
                wr_active = 1'b1;
            end
            if (w_i.wvalid && w_ready_o) begin
                mem[wr_addr] = w_i.wdata;
                wr_addr      = (wr_addr + 1) % MEM_WORDS;
                if (w_i.wlast) begin
                    wr_active = 1'b0;
                    b_pend    = 1'b1;
                end
            end
            if (b_o.bvalid && b_ready_i) begin
                b_pend = 1'b0;
            end

            nxt_ar_ready = mask_i[0];
            nxt_aw_ready = mask_i[2];
            nxt_w_ready  = wr_active && mask_i[3];
            // a raised beat holds until it transfers
            if (r_o.rvalid && !r_fire) begin
                nxt_r = r_o;
            end else begin
                nxt_r = '0;
                if (((rd_left[0] != 0) || (rd_left[1] != 0)) && mask_i[1]) begin
                    // both IDs pending, mask bit 5 interleaves them
                    sel_id = ((rd_left[0] != 0) && (rd_left[1] != 0)) ? mask_i[5]
                                                                      : (rd_left[1] != 0);
                    nxt_r.rvalid = 1'b1;
                    nxt_r.rid    = axi_id_t'(sel_id);
                    nxt_r.rdata  = mem[rd_addr[sel_id]];
                    nxt_r.rlast  = (rd_left[sel_id] == 1);
                end
            end
            nxt_b        = '0;
            nxt_b.bvalid = b_pend && (b_o.bvalid || mask_i[4]);
        end
    end

    // ports change on the falling edge
    always @(negedge clk) begin
        ar_ready_q <= nxt_ar_ready;
        aw_ready_q <= nxt_aw_ready;
        w_ready_q  <= nxt_w_ready;
        r_q        <= nxt_r;
        b_q        <= nxt_b;
    end

endmodule

//--- bench/mm_accel_tb.sv
`timescale 1ns/1ps

/*
 * mm_accel_tb
 * runs a table of matrix products through the accelerator and checks
 * C, the AXI bursts and the untouched memory against a reference multiply
 */
module mm_accel_tb;
    import axi_pkg::*;
    import mm_pkg::*;

    localparam int NUM_ROWS  = 5;
    localparam int MEM_WORDS = 1024;
    localparam int N         = 4;

    localparam logic [1:0] KIND_IDENT   = 2'd0;
    localparam logic [1:0] KIND_RAND    = 2'd1;
    localparam logic [1:0] KIND_EXTREME = 2'd2;

    typedef struct packed {
        axi_addr_t  a_addr;
        axi_addr_t  b_addr;
        axi_addr_t  c_addr;
        logic [1:0] kind;
        logic       stall;
    } test_row_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      start;
    mat_cfg_t  cfg;
    logic      done;
    axi_ar_t   ar;
    logic      ar_ready;
    axi_r_t    r;
    logic      r_ready;
    axi_aw_t   aw;
    logic      aw_ready;
    axi_w_t    w;
    logic      w_ready;
    axi_b_t    b;
    logic      b_ready;
    logic [5:0] ready_mask = 6'h3f;
    logic       stall_en   = 1'b0;

    logic [31:0] mat_seed   = 32'h0368b503;
    logic [31:0] stall_seed = ~32'h0368b503;
    axi_data_t   a_m [N][N];
    axi_data_t   b_m [N][N];
    test_row_t   tests [NUM_ROWS];
    int          ar_cnt;
    int          aw_cnt;
    int          w_beats;
    logic        b_seen;

    always #2 clk = ~clk;

    mm_accel_top #(
        .DW       (32),
        .SA_WIDTH (N),
        .BUF_AW   (6)
    ) mm_accel_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_i      (cfg),
        .start_i    (start),
        .done_o     (done),
        .ar_o       (ar),
        .ar_ready_i (ar_ready),
        .r_i        (r),
        .r_ready_o  (r_ready),
        .aw_o       (aw),
        .aw_ready_i (aw_ready),
        .w_o        (w),
        .w_ready_i  (w_ready),
        .b_i        (b),
        .b_ready_o  (b_ready)
    );

    axi_mem_model #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_model_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .mask_i     (ready_mask),
        .ar_i       (ar),
        .ar_ready_o (ar_ready),
        .r_o        (r),
        .r_ready_i  (r_ready),
        .aw_i       (aw),
        .aw_ready_o (aw_ready),
        .w_i        (w),
        .w_ready_o  (w_ready),
        .b_o        (b),
        .b_ready_i  (b_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        mat_seed = lcg_next(mat_seed);
        return mat_seed;
    endfunction

    function automatic axi_data_t fill_word(input int idx);
        return (axi_data_t'(idx) * 32'h9e3779b1) ^ 32'ha5a5_0000;
    endfunction

    // signed sum of products with only the low 32 bits kept
    function automatic axi_data_t expected_c(input int i, input int j);
        longint s;
        s = 0;
        for (int k = 0; k < N; k++) begin
            s += longint'($signed(a_m[i][k])) * longint'($signed(b_m[k][j]));
        end
        return s[31:0];
    endfunction

    function automatic logic in_region(input int idx, input axi_addr_t base);
        return (idx >= int'(base >> 2)) && (idx < int'(base >> 2) + N * N);
    endfunction

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input axi_data_t got, input axi_data_t exp, input string name);
        if (got !== exp) begin
            report_fail($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                  $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input axi_addr_t got, input axi_addr_t exp, input string name);
        if (got !== exp) begin
            report_fail($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                  $time, name, got, exp));
        end
    endtask

    task automatic check_len(input axi_len_t got, input axi_len_t exp, input string name);
        if (got !== exp) begin
            report_fail($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                                  $time, name, got, exp));
        end
    endtask

    // all handshake outputs low while the DMA sits idle
    task automatic check_idle();
        check_word(axi_data_t'(ar.arvalid), 32'd0, "arvalid");
        check_word(axi_data_t'(aw.awvalid), 32'd0, "awvalid");
        check_word(axi_data_t'(w.wvalid), 32'd0, "wvalid");
        check_word(axi_data_t'(r_ready), 32'd0, "r_ready");
        check_word(axi_data_t'(b_ready), 32'd0, "b_ready");
        check_word(axi_data_t'(done), 32'd0, "done");
    endtask

    always @(negedge clk) begin
        stall_seed = lcg_next(stall_seed);
        ready_mask <= stall_en ? stall_seed[21:16] : {stall_seed[21], 5'h1f};
    end

    // burst monitor on the AXI channels
    always @(posedge clk) begin
        if (rst_n) begin
            if (ar.arvalid && ar_ready) begin
                check_word(axi_data_t'(ar.arid), axi_data_t'(ar_cnt), "arid");
                check_addr(ar.araddr, (ar_cnt == 0) ? cfg.mat_a_addr : cfg.mat_b_addr,
                           "araddr");
                check_len(ar.arlen, 8'd15, "arlen");
                check_word(axi_data_t'(ar.arsize), 32'd2, "arsize");
                check_word(axi_data_t'(ar.arburst), 32'd1, "arburst");
                ar_cnt++;
            end
            if (aw.awvalid && aw_ready) begin
                check_word(axi_data_t'(aw.awid), 32'd0, "awid");
                check_addr(aw.awaddr, cfg.mat_c_addr, "awaddr");
                check_len(aw.awlen, 8'd15, "awlen");
                check_word(axi_data_t'(aw.awsize), 32'd2, "awsize");
                check_word(axi_data_t'(aw.awburst), 32'd1, "awburst");
                aw_cnt++;
            end
            if (w.wvalid && w_ready) begin
                check_word(axi_data_t'(w.wlast), axi_data_t'(w_beats == N * N - 1), "wlast");
                check_word(axi_data_t'(w.wstrb), 32'hf, "wstrb");
                w_beats++;
            end
            if (b.bvalid && b_ready) begin
                b_seen = 1'b1;
            end
            if (done && !b_seen) begin
                report_fail("done_o pulsed before the write response was received");
            end
        end
    end

    task automatic load_matrices(input test_row_t t);
        logic [31:0] rv;
        for (int idx = 0; idx < MEM_WORDS; idx++) begin
            mem_model_inst.mem[idx] = fill_word(idx);
        end
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                rv = next_rand();
                case (t.kind)
                    KIND_IDENT:   a_m[i][j] = axi_data_t'(i == j);
                    KIND_EXTREME: a_m[i][j] = rv[31] ? 32'h8000_0000 : 32'h7fff_ffff;
                    default:      a_m[i][j] = next_rand();
                endcase
                b_m[i][j] = (t.kind == KIND_EXTREME) ? (rv[30] ? 32'h8000_0000 : 32'h7fff_ffff)
                                                     : next_rand();
            end
        end
        // A is laid out column-major and B row-major
        for (int k = 0; k < N; k++) begin
            for (int e = 0; e < N; e++) begin
                mem_model_inst.mem[int'(t.a_addr >> 2) + k * N + e] = a_m[e][k];
                mem_model_inst.mem[int'(t.b_addr >> 2) + k * N + e] = b_m[k][e];
            end
        end
    endtask

    task automatic check_results(input test_row_t t);
        int c_base;
        c_base = int'(t.c_addr >> 2);
        check_idle();
        check_word(axi_data_t'(ar_cnt), 32'd2, "read bursts");
        check_word(axi_data_t'(aw_cnt), 32'd1, "write bursts");
        check_word(axi_data_t'(w_beats), 32'd16, "write beats");
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                check_word(mem_model_inst.mem[c_base + i * N + j], expected_c(i, j),
                           $sformatf("C[%0d][%0d]", i, j));
            end
        end
        for (int idx = 0; idx < MEM_WORDS; idx++) begin
            if (!in_region(idx, t.a_addr) && !in_region(idx, t.b_addr) &&
                !in_region(idx, t.c_addr)) begin
                check_word(mem_model_inst.mem[idx], fill_word(idx),
                           $sformatf("mem[%0d]", idx));
            end
        end
    endtask

    initial begin
        repeat (NUM_ROWS * 2000) @(posedge clk);
        $display("watchdog expired before all test rows finished");
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        tests[0] = '{32'h000, 32'h100, 32'h200, KIND_IDENT,   1'b0};
        tests[1] = '{32'h300, 32'h340, 32'h380, KIND_RAND,    1'b0};
        tests[2] = '{32'h400, 32'h500, 32'h600, KIND_EXTREME, 1'b1};
        tests[3] = '{32'h800, 32'h840, 32'h880, KIND_RAND,    1'b1};
        tests[4] = '{32'hc00, 32'h040, 32'hf00, KIND_RAND,    1'b1};
        rst_n  = 1'b0;
        start  = 1'b0;
        cfg    = '0;
        ar_cnt = 0;
        aw_cnt = 0;
        w_beats = 0;
        b_seen = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_idle();

        for (int t = 0; t < NUM_ROWS; t++) begin
            @(negedge clk);
            load_matrices(tests[t]);
            cfg      = '{tests[t].a_addr, tests[t].b_addr, tests[t].c_addr};
            stall_en = tests[t].stall;
            ar_cnt   = 0;
            aw_cnt   = 0;
            w_beats  = 0;
            b_seen   = 1'b0;
            start    = 1'b1;
            @(negedge clk);
            start = 1'b0;
            // a second start while busy must not cause another burst
            while (ar_cnt == 0) @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            while (!done) @(negedge clk);
            repeat (2) @(negedge clk);
            check_results(tests[t]);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f verilog.f --top-module mm_accel_tb -o mm_accel_sim \
    > sim.log 2>&1 \
    && ./obj_dir/mm_accel_sim >> sim.log 2>&1 \
    || echo "build or run error" >> sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; } \
    || grep -q "TEST RESULT: PASS" sim.log && { echo "simulation passed"; exit 0; } \
    || { echo "no result in sim.log"; exit 1; }

//--- verilog.f
verilog/axi_pkg.sv
verilog/mm_pkg.sv
verilog/mat_buffer.sv
verilog/mm_engine.sv
verilog/dma_engine.sv
verilog/mm_accel_top.sv
bench/axi_mem_model.sv
bench/mm_accel_tb.sv

//--- verilog/axi_pkg.sv
/*
 * axi_pkg
 * AXI4 field widths, encodings and the packed channel bundles
 */
package axi_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  axi_len_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [1:0]  axi_resp_t;

    // 4-byte beats, incrementing bursts
    localparam axi_size_t  AXI_SIZE_4B    = 3'd2;
    localparam axi_burst_t AXI_BURST_INCR = 2'b01;

    typedef struct packed {
        logic       arvalid;
        axi_id_t    arid;
        axi_addr_t  araddr;
        axi_len_t   arlen;
        axi_size_t  arsize;
        axi_burst_t arburst;
    } axi_ar_t;

    typedef struct packed {
        logic      rvalid;
        axi_id_t   rid;
        axi_data_t rdata;
        logic      rlast;
    } axi_r_t;

    typedef struct packed {
        logic       awvalid;
        axi_id_t    awid;
        axi_addr_t  awaddr;
        axi_len_t   awlen;
        axi_size_t  awsize;
        axi_burst_t awburst;
    } axi_aw_t;

    typedef struct packed {
        logic      wvalid;
        axi_data_t wdata;
        axi_strb_t wstrb;
        logic      wlast;
    } axi_w_t;

    typedef struct packed {
        logic      bvalid;
        axi_id_t   bid;
        axi_resp_t bresp;
    } axi_b_t;

endpackage

//--- verilog/dma_engine.sv
`timescale 1ns/1ps

/*
 * dma_engine
 * reads A and B over AXI into the operand buffers, starts the multiply
 * engine, then writes the product matrix C back as one write burst
 */
module dma_engine #(
    parameter int DW       = 32,
    parameter int SA_WIDTH = 4,
    parameter int BUF_AW   = 6
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  mm_pkg::mat_cfg_t                      cfg_i,
    input  logic                                  start_i,
    output logic                                  done_o,
    output axi_pkg::axi_ar_t                      ar_o,
    input  logic                                  ar_ready_i,
    input  axi_pkg::axi_r_t                       r_i,
    output logic                                  r_ready_o,
    output axi_pkg::axi_aw_t                      aw_o,
    input  logic                                  aw_ready_i,
    output axi_pkg::axi_w_t                       w_o,
    input  logic                                  w_ready_i,
    input  axi_pkg::axi_b_t                       b_i,
    output logic                                  b_ready_o,
    output logic                                  buf_a_wren_o,
    output logic [BUF_AW-1:0]                     buf_a_waddr_o,
    output logic [SA_WIDTH*DW-1:0]                buf_a_wdata_o,
    output logic                                  buf_b_wren_o,
    output logic [BUF_AW-1:0]                     buf_b_waddr_o,
    output logic [SA_WIDTH*DW-1:0]                buf_b_wdata_o,
    output logic                                  mm_start_o,
    input  logic                                  mm_done_i,
    input  logic [SA_WIDTH*SA_WIDTH*(2*DW+1)-1:0] accum_i
);
    import axi_pkg::*;
    import mm_pkg::*;

    localparam int BUF_DW = SA_WIDTH * DW;
    localparam int ACC_W  = 2 * DW + 1;
    localparam int N_ELEM = SA_WIDTH * SA_WIDTH;
    localparam int WCNT_W = (SA_WIDTH > 1) ? $clog2(SA_WIDTH) : 1;
    localparam int ECNT_W = (N_ELEM > 1) ? $clog2(N_ELEM) : 1;

    localparam axi_len_t BURST_LEN = axi_len_t'(N_ELEM - 1);

    typedef logic [WCNT_W-1:0]       word_cnt_t;
    typedef logic [ECNT_W-1:0]       elem_cnt_t;
    typedef logic [BUF_AW-1:0]       row_addr_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    localparam word_cnt_t WORD_LAST = word_cnt_t'(SA_WIDTH - 1);
    localparam elem_cnt_t ELEM_LAST = elem_cnt_t'(N_ELEM - 1);
    localparam row_addr_t ROW_LAST  = row_addr_t'(SA_WIDTH - 1);
    localparam row_addr_t ROW_FULL  = row_addr_t'(SA_WIDTH);

    dma_state_e        state;
    word_cnt_t         wcnt_a;
    word_cnt_t         wcnt_b;
    row_addr_t         row_a;
    row_addr_t         row_b;
    logic [BUF_DW-1:0] sreg_a;
    logic [BUF_DW-1:0] sreg_b;
    elem_cnt_t         ecnt;
    acc_t              acc_sel;
    logic              beat_a;
    logic              beat_b;
    logic              full_a_next;
    logic              full_b_next;
    logic              w_fire;

    // R beats are steered by ID, 0 is A and 1 is B
    assign r_ready_o = (state == ADDR_B) || (state == LOAD);
    assign beat_a    = r_i.rvalid && r_ready_o && (r_i.rid == axi_id_t'(0));
    assign beat_b    = r_i.rvalid && r_ready_o && (r_i.rid == axi_id_t'(1));

    // buffer full once its last row is written, counting the pending write
    assign full_a_next = (row_a == ROW_FULL) || (buf_a_wren_o && (row_a == ROW_LAST));
    assign full_b_next = (row_b == ROW_FULL) || (buf_b_wren_o && (row_b == ROW_LAST));

    always_comb begin
        ar_o         = '0;
        ar_o.arvalid = (state == ADDR_A) || (state == ADDR_B);
        ar_o.arid    = (state == ADDR_B) ? axi_id_t'(1) : axi_id_t'(0);
        ar_o.araddr  = (state == ADDR_B) ? cfg_i.mat_b_addr : cfg_i.mat_a_addr;
        ar_o.arlen   = BURST_LEN;
        ar_o.arsize  = AXI_SIZE_4B;
        ar_o.arburst = AXI_BURST_INCR;
    end

    always_comb begin
        aw_o         = '0;
        aw_o.awvalid = (state == ADDR_C);
        aw_o.awid    = axi_id_t'(0);
        aw_o.awaddr  = cfg_i.mat_c_addr;
        aw_o.awlen   = BURST_LEN;
        aw_o.awsize  = AXI_SIZE_4B;
        aw_o.awburst = AXI_BURST_INCR;
    end

    // C goes out row-major, so the element count is the flat index
    assign acc_sel = accum_i[ecnt*ACC_W +: ACC_W];

    always_comb begin
        w_o        = '0;
        w_o.wvalid = (state == WRITE_C);
        w_o.wdata  = axi_data_t'(acc_sel);
        w_o.wstrb  = '1;
        w_o.wlast  = (ecnt == ELEM_LAST);
    end

    assign w_fire    = w_o.wvalid && w_ready_i;
    assign b_ready_o = (state == WAIT_B);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            ecnt       <= '0;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state <= ADDR_A;
                        ecnt  <= '0;
                    end
                end
                ADDR_A: begin
                    if (ar_ready_i) begin
                        state <= ADDR_B;
                    end
                end
                ADDR_B: begin
                    if (ar_ready_i) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    if (full_a_next && full_b_next) begin
                        state      <= WAIT_MM;
                        mm_start_o <= 1'b1;
                    end
                end
                WAIT_MM: begin
                    if (mm_done_i) begin
                        state <= ADDR_C;
                    end
                end
                ADDR_C: begin
                    if (aw_ready_i) begin
                        state <= WRITE_C;
                    end
                end
                WRITE_C: begin
                    if (w_fire) begin
                        ecnt <= ecnt + 1'b1;
                        if (w_o.wlast) begin
                            state <= WAIT_B;
                        end
                    end
                end
                WAIT_B: begin
                    if (b_i.bvalid) begin
                        state  <= IDLE;
                        done_o <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // per-ID word and row counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wcnt_a       <= '0;
            wcnt_b       <= '0;
            row_a        <= '0;
            row_b        <= '0;
            buf_a_wren_o <= 1'b0;
            buf_b_wren_o <= 1'b0;
        end else if ((state == IDLE) && start_i) begin
            wcnt_a       <= '0;
            wcnt_b       <= '0;
            row_a        <= '0;
            row_b        <= '0;
            buf_a_wren_o <= 1'b0;
            buf_b_wren_o <= 1'b0;
        end else begin
            // row write follows the 4th beat by one cycle
            buf_a_wren_o <= beat_a && (wcnt_a == WORD_LAST);
            buf_b_wren_o <= beat_b && (wcnt_b == WORD_LAST);
            if (beat_a) begin
                wcnt_a <= (wcnt_a == WORD_LAST) ? '0 : wcnt_a + 1'b1;
            end
            if (beat_b) begin
                wcnt_b <= (wcnt_b == WORD_LAST) ? '0 : wcnt_b + 1'b1;
            end
            if (buf_a_wren_o) begin
                row_a <= row_a + 1'b1;
            end
            if (buf_b_wren_o) begin
                row_b <= row_b + 1'b1;
            end
        end
    end

    // new word enters at the top, so element 0 lands in the low bits
    always_ff @(posedge clk) begin
        if (beat_a) begin
            sreg_a <= {r_i.rdata[DW-1:0], sreg_a[BUF_DW-1:DW]};
        end
        if (beat_b) begin
            sreg_b <= {r_i.rdata[DW-1:0], sreg_b[BUF_DW-1:DW]};
        end
    end

    assign buf_a_waddr_o = row_a;
    assign buf_a_wdata_o = sreg_a;
    assign buf_b_waddr_o = row_b;
    assign buf_b_wdata_o = sreg_b;

endmodule

//--- verilog/mat_buffer.sv
`timescale 1ns/1ps

/*
 * mat_buffer
 * row storage for one matrix operand, one write and one registered read port
 */
module mat_buffer #(
    parameter int DW       = 32,
    parameter int SA_WIDTH = 4,
    parameter int BUF_AW   = 6
) (
    input  logic                   clk,
    input  logic                   wren_i,
    input  logic [BUF_AW-1:0]      waddr_i,
    input  logic [SA_WIDTH*DW-1:0] wdata_i,
    input  logic [BUF_AW-1:0]      raddr_i,
    output logic [SA_WIDTH*DW-1:0] rdata_o
);
    localparam int BUF_DW = SA_WIDTH * DW;

    logic [BUF_DW-1:0] mem [2**BUF_AW];

    always_ff @(posedge clk) begin
        if (wren_i) begin
            mem[waddr_i] <= wdata_i;
        end
        // data one cycle after the address
        rdata_o <= mem[raddr_i];
    end

endmodule

//--- verilog/mm_accel_top.sv
`timescale 1ns/1ps

/*
 * mm_accel_top
 * matrix-multiply accelerator, DMA engine feeding two operand buffers
 * and the multiply engine, with one AXI master port to memory
 */
module mm_accel_top #(
    parameter int DW       = 32,
    parameter int SA_WIDTH = 4,
    parameter int BUF_AW   = 6
) (
    input  logic              clk,
    input  logic              rst_n,
    input  mm_pkg::mat_cfg_t  cfg_i,
    input  logic              start_i,
    output logic              done_o,
    output axi_pkg::axi_ar_t  ar_o,
    input  logic              ar_ready_i,
    input  axi_pkg::axi_r_t   r_i,
    output logic              r_ready_o,
    output axi_pkg::axi_aw_t  aw_o,
    input  logic              aw_ready_i,
    output axi_pkg::axi_w_t   w_o,
    input  logic              w_ready_i,
    input  axi_pkg::axi_b_t   b_i,
    output logic              b_ready_o
);
    localparam int BUF_DW = SA_WIDTH * DW;
    localparam int ACC_BITS = SA_WIDTH * SA_WIDTH * (2 * DW + 1);

    logic                buf_a_wren;
    logic [BUF_AW-1:0]   buf_a_waddr;
    logic [BUF_DW-1:0]   buf_a_wdata;
    logic [BUF_AW-1:0]   buf_a_raddr;
    logic [BUF_DW-1:0]   buf_a_rdata;
    logic                buf_b_wren;
    logic [BUF_AW-1:0]   buf_b_waddr;
    logic [BUF_DW-1:0]   buf_b_wdata;
    logic [BUF_AW-1:0]   buf_b_raddr;
    logic [BUF_DW-1:0]   buf_b_rdata;
    logic                mm_start;
    logic                mm_done;
    logic [ACC_BITS-1:0] accum;

    dma_engine #(
        .DW       (DW),
        .SA_WIDTH (SA_WIDTH),
        .BUF_AW   (BUF_AW)
    ) dma_engine_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_i         (cfg_i),
        .start_i       (start_i),
        .done_o        (done_o),
        .ar_o          (ar_o),
        .ar_ready_i    (ar_ready_i),
        .r_i           (r_i),
        .r_ready_o     (r_ready_o),
        .aw_o          (aw_o),
        .aw_ready_i    (aw_ready_i),
        .w_o           (w_o),
        .w_ready_i     (w_ready_i),
        .b_i           (b_i),
        .b_ready_o     (b_ready_o),
        .buf_a_wren_o  (buf_a_wren),
        .buf_a_waddr_o (buf_a_waddr),
        .buf_a_wdata_o (buf_a_wdata),
        .buf_b_wren_o  (buf_b_wren),
        .buf_b_waddr_o (buf_b_waddr),
        .buf_b_wdata_o (buf_b_wdata),
        .mm_start_o    (mm_start),
        .mm_done_i     (mm_done),
        .accum_i       (accum)
    );

    // A holds columns, B holds rows
    mat_buffer #(
        .DW       (DW),
        .SA_WIDTH (SA_WIDTH),
        .BUF_AW   (BUF_AW)
    ) buf_a_inst (
        .clk     (clk),
        .wren_i  (buf_a_wren),
        .waddr_i (buf_a_waddr),
        .wdata_i (buf_a_wdata),
        .raddr_i (buf_a_raddr),
        .rdata_o (buf_a_rdata)
    );

    mat_buffer #(
        .DW       (DW),
        .SA_WIDTH (SA_WIDTH),
        .BUF_AW   (BUF_AW)
    ) buf_b_inst (
        .clk     (clk),
        .wren_i  (buf_b_wren),
        .waddr_i (buf_b_waddr),
        .wdata_i (buf_b_wdata),
        .raddr_i (buf_b_raddr),
        .rdata_o (buf_b_rdata)
    );

    mm_engine #(
        .DW       (DW),
        .SA_WIDTH (SA_WIDTH),
        .BUF_AW   (BUF_AW)
    ) mm_engine_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (mm_start),
        .buf_a_raddr_o (buf_a_raddr),
        .buf_a_rdata_i (buf_a_rdata),
        .buf_b_raddr_o (buf_b_raddr),
        .buf_b_rdata_i (buf_b_rdata),
        .done_o        (mm_done),
        .accum_o       (accum)
    );

endmodule

//--- verilog/mm_engine.sv
`timescale 1ns/1ps

/*
 * mm_engine
 * accumulates the outer product of A column k and B row k for every k
 * into a square array of signed accumulators
 */
module mm_engine #(
    parameter int DW       = 32,
    parameter int SA_WIDTH = 4,
    parameter int BUF_AW   = 6
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start_i,
    output logic [BUF_AW-1:0]                     buf_a_raddr_o,
    input  logic [SA_WIDTH*DW-1:0]                buf_a_rdata_i,
    output logic [BUF_AW-1:0]                     buf_b_raddr_o,
    input  logic [SA_WIDTH*DW-1:0]                buf_b_rdata_i,
    output logic                                  done_o,
    output logic [SA_WIDTH*SA_WIDTH*(2*DW+1)-1:0] accum_o
);
    import mm_pkg::*;

    localparam int ACC_W = 2 * DW + 1;

    typedef logic signed [DW-1:0]    elem_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic [BUF_AW-1:0]       step_t;

    localparam step_t STEP_LAST = step_t'(SA_WIDTH - 1);

    mm_state_e state;
    step_t     k;
    logic      acc_en;
    elem_t     a_el [SA_WIDTH];
    elem_t     b_el [SA_WIDTH];
    acc_t      prod [SA_WIDTH][SA_WIDTH];
    acc_t      acc  [SA_WIDTH][SA_WIDTH];

    // step sequencer, k addresses both buffers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= MM_IDLE;
            k      <= '0;
            acc_en <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            // buffer data for step k arrives one cycle later
            acc_en <= (state == MM_RUN);
            case (state)
                MM_IDLE: begin
                    if (start_i) begin
                        state <= MM_RUN;
                        k     <= '0;
                    end
                end
                MM_RUN: begin
                    if (k == STEP_LAST) begin
                        state <= MM_DRAIN;
                    end else begin
                        k <= k + 1'b1;
                    end
                end
                MM_DRAIN: begin
                    // last product lands on this edge
                    state  <= MM_IDLE;
                    done_o <= 1'b1;
                end
                default: state <= MM_IDLE;
            endcase
        end
    end

    assign buf_a_raddr_o = k;
    assign buf_b_raddr_o = k;

    always_comb begin
        for (int i = 0; i < SA_WIDTH; i++) begin
            a_el[i] = elem_t'(buf_a_rdata_i[i*DW +: DW]);
            b_el[i] = elem_t'(buf_b_rdata_i[i*DW +: DW]);
        end
        for (int i = 0; i < SA_WIDTH; i++) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                prod[i][j] = acc_t'(a_el[i]) * acc_t'(b_el[j]);
            end
        end
    end

    // cleared on start, held after done until the next start
    always_ff @(posedge clk) begin
        for (int i = 0; i < SA_WIDTH; i++) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                if ((state == MM_IDLE) && start_i) begin
                    acc[i][j] <= '0;
                end else if (acc_en) begin
                    acc[i][j] <= acc[i][j] + prod[i][j];
                end
            end
        end
    end

    // row-major packing, element (i, j) at flat index i*SA_WIDTH+j
    always_comb begin
        for (int i = 0; i < SA_WIDTH; i++) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                accum_o[(i*SA_WIDTH+j)*ACC_W +: ACC_W] = acc[i][j];
            end
        end
    end

endmodule

//--- verilog/mm_pkg.sv
/*
 * mm_pkg
 * accelerator configuration and the state encodings of its FSMs
 */
package mm_pkg;

    // base byte addresses of the three matrices
    typedef struct packed {
        axi_pkg::axi_addr_t mat_a_addr;
        axi_pkg::axi_addr_t mat_b_addr;
        axi_pkg::axi_addr_t mat_c_addr;
    } mat_cfg_t;

    typedef enum logic [2:0] {
        IDLE,
        ADDR_A,
        ADDR_B,
        LOAD,
        WAIT_MM,
        ADDR_C,
        WRITE_C,
        WAIT_B
    } dma_state_e;

    // prefixed, the DMA states already own IDLE
    typedef enum logic [1:0] {
        MM_IDLE,
        MM_RUN,
        MM_DRAIN
    } mm_state_e;

endpackage
